/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;

	// major opcodes handled by the core
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// alu functions, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

endpackage

/* verilog/rv_pipe_pkg.sv */
package rv_pipe_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B,
		ALU_LINK
	} alu_op_e;

	typedef enum logic {
		SRC_A_RS1,
		SRC_A_PC
	} src_a_e;

	typedef enum logic {
		SRC_B_RS2,
		SRC_B_IMM
	} src_b_e;

	// how the next pc is formed
	typedef enum logic [1:0] {
		FLOW_SEQ,
		FLOW_BRANCH,
		FLOW_JAL,
		FLOW_JALR
	} flow_e;

	// branch condition, same coding as funct3
	typedef logic [2:0] cmp_e;

endpackage

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_isa_pkg::reg_addr_t rs1_addr_i,
	input  rv_isa_pkg::reg_addr_t rs2_addr_i,
	input  logic                  wr_en_i,
	input  rv_isa_pkg::reg_addr_t wr_addr_i,
	input  rv_isa_pkg::xlen_t     wr_data_i,
	output rv_isa_pkg::xlen_t     rs1_data_o,
	output rv_isa_pkg::xlen_t     rs2_data_o
);
	import rv_isa_pkg::*;

	// x0 has no storage
	xlen_t regs [1:31];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  in_valid_i,
	input  rv_isa_pkg::xlen_t     in_pc_i,
	input  rv_isa_pkg::inst_t     in_inst_i,
	input  logic                  advance_i,
	input  rv_isa_pkg::xlen_t     rs1_data_i,
	input  rv_isa_pkg::xlen_t     rs2_data_i,
	input  rv_isa_pkg::xlen_t     ex_result_i,
	input  logic                  wb_rd_wen_i,
	input  rv_isa_pkg::reg_addr_t wb_rd_addr_i,
	input  rv_isa_pkg::xlen_t     wb_rd_data_i,
	output rv_isa_pkg::reg_addr_t rs1_addr_o,
	output rv_isa_pkg::reg_addr_t rs2_addr_o,
	output logic                  ex_valid_o,
	output rv_isa_pkg::xlen_t     ex_pc_o,
	output rv_isa_pkg::xlen_t     ex_rs1_o,
	output rv_isa_pkg::xlen_t     ex_rs2_o,
	output rv_isa_pkg::xlen_t     ex_imm_o,
	output rv_pipe_pkg::alu_op_e  ex_alu_op_o,
	output rv_pipe_pkg::src_a_e   ex_src_a_o,
	output rv_pipe_pkg::src_b_e   ex_src_b_o,
	output rv_pipe_pkg::flow_e    ex_flow_o,
	output rv_pipe_pkg::cmp_e     ex_cmp_o,
	output logic                  ex_rd_wen_o,
	output rv_isa_pkg::reg_addr_t ex_rd_addr_o
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	opcode_e   opcode;
	logic [2:0] funct3;
	logic      funct7_b5;
	reg_addr_t rd_addr;
	xlen_t     imm;
	alu_op_e   alu_op;
	src_a_e    src_a;
	src_b_e    src_b;
	flow_e     flow;
	logic      rd_wen;
	xlen_t     rs1_fwd;
	xlen_t     rs2_fwd;

	// alt selects sub or sra
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return alt ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// youngest producer wins, x0 is always zero
	function automatic xlen_t fwd_sel(input reg_addr_t addr, input xlen_t rf_data);
		if (addr == '0)
			return '0;
		if (ex_valid_o && ex_rd_wen_o && ex_rd_addr_o == addr)
			return ex_result_i;
		if (wb_rd_wen_i && wb_rd_addr_i == addr)
			return wb_rd_data_i;
		return rf_data;
	endfunction

	assign opcode     = opcode_e'(in_inst_i[6:0]);
	assign funct3     = in_inst_i[14:12];
	assign funct7_b5  = in_inst_i[30];
	assign rd_addr    = in_inst_i[11:7];
	assign rs1_addr_o = in_inst_i[19:15];
	assign rs2_addr_o = in_inst_i[24:20];

	always_comb begin
		imm    = {{20{in_inst_i[31]}}, in_inst_i[31:20]};
		alu_op = ALU_ADD;
		src_a  = SRC_A_RS1;
		src_b  = SRC_B_IMM;
		flow   = FLOW_SEQ;
		rd_wen = 1'b0;
		case (opcode)
			OP_LUI: begin
				imm    = {in_inst_i[31:12], 12'b0};
				alu_op = ALU_PASS_B;
				rd_wen = 1'b1;
			end
			OP_AUIPC: begin
				imm    = {in_inst_i[31:12], 12'b0};
				src_a  = SRC_A_PC;
				rd_wen = 1'b1;
			end
			OP_JAL: begin
				imm    = {{12{in_inst_i[31]}}, in_inst_i[19:12], in_inst_i[20],
					in_inst_i[30:21], 1'b0};
				alu_op = ALU_LINK;
				flow   = FLOW_JAL;
				rd_wen = 1'b1;
			end
			OP_JALR: begin
				alu_op = ALU_LINK;
				flow   = FLOW_JALR;
				rd_wen = 1'b1;
			end
			OP_BRANCH: begin
				imm   = {{20{in_inst_i[31]}}, in_inst_i[7], in_inst_i[30:25],
					in_inst_i[11:8], 1'b0};
				src_b = SRC_B_RS2;
				flow  = FLOW_BRANCH;
			end
			OP_IMM: begin
				// only the shift encoding uses bit 30 here
				alu_op = alu_sel(funct3, funct7_b5 && funct3 == F3_SR);
				rd_wen = 1'b1;
			end
			OP_REG: begin
				alu_op = alu_sel(funct3, funct7_b5);
				src_b  = SRC_B_RS2;
				rd_wen = 1'b1;
			end
			default: begin
				rd_wen = 1'b0;
			end
		endcase
		if (rd_addr == '0)
			rd_wen = 1'b0;
	end

	always_comb begin
		rs1_fwd = fwd_sel(rs1_addr_o, rs1_data_i);
		rs2_fwd = fwd_sel(rs2_addr_o, rs2_data_i);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid_o <= 1'b0;
		end else if (advance_i) begin
			ex_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (advance_i) begin
			ex_pc_o      <= in_pc_i;
			ex_rs1_o     <= rs1_fwd;
			ex_rs2_o     <= rs2_fwd;
			ex_imm_o     <= imm;
			ex_alu_op_o  <= alu_op;
			ex_src_a_o   <= src_a;
			ex_src_b_o   <= src_b;
			ex_flow_o    <= flow;
			ex_cmp_o     <= funct3;
			ex_rd_wen_o  <= rd_wen;
			ex_rd_addr_o <= rd_addr;
		end
	end

endmodule

/* verilog/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
	input  rv_isa_pkg::xlen_t    ex_pc_i,
	input  rv_isa_pkg::xlen_t    ex_rs1_i,
	input  rv_isa_pkg::xlen_t    ex_rs2_i,
	input  rv_isa_pkg::xlen_t    ex_imm_i,
	input  rv_pipe_pkg::alu_op_e ex_alu_op_i,
	input  rv_pipe_pkg::src_a_e  ex_src_a_i,
	input  rv_pipe_pkg::src_b_e  ex_src_b_i,
	output rv_isa_pkg::xlen_t    result_o
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	xlen_t      op_a;
	xlen_t      op_b;
	logic [4:0] shamt;

	assign op_a  = (ex_src_a_i == SRC_A_PC) ? ex_pc_i : ex_rs1_i;
	assign op_b  = (ex_src_b_i == SRC_B_IMM) ? ex_imm_i : ex_rs2_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ex_alu_op_i)
			ALU_ADD:    result_o = op_a + op_b;
			ALU_SUB:    result_o = op_a - op_b;
			ALU_SLL:    result_o = op_a << shamt;
			ALU_SLT:    result_o = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   result_o = {31'b0, op_a < op_b};
			ALU_XOR:    result_o = op_a ^ op_b;
			ALU_SRL:    result_o = op_a >> shamt;
			ALU_SRA:    result_o = xlen_t'($signed(op_a) >>> shamt);
			ALU_OR:     result_o = op_a | op_b;
			ALU_AND:    result_o = op_a & op_b;
			ALU_PASS_B: result_o = op_b;
			// return address for jal and jalr
			ALU_LINK:   result_o = ex_pc_i + 32'd4;
			default:    result_o = op_a + op_b;
		endcase
	end

endmodule

/* verilog/rv_branch_unit.sv */
`timescale 1ns/1ps

module rv_branch_unit (
	input  rv_isa_pkg::xlen_t  ex_pc_i,
	input  rv_isa_pkg::xlen_t  ex_rs1_i,
	input  rv_isa_pkg::xlen_t  ex_imm_i,
	input  rv_isa_pkg::xlen_t  ex_rs2_i,
	input  rv_pipe_pkg::flow_e ex_flow_i,
	input  rv_pipe_pkg::cmp_e  ex_cmp_i,
	output rv_isa_pkg::xlen_t  next_pc_o
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	logic  taken;
	xlen_t jalr_target;

	always_comb begin
		case (ex_cmp_i)
			F3_BEQ:  taken = (ex_rs1_i == ex_rs2_i);
			F3_BNE:  taken = (ex_rs1_i != ex_rs2_i);
			F3_BLT:  taken = ($signed(ex_rs1_i) < $signed(ex_rs2_i));
			F3_BGE:  taken = ($signed(ex_rs1_i) >= $signed(ex_rs2_i));
			F3_BLTU: taken = (ex_rs1_i < ex_rs2_i);
			F3_BGEU: taken = (ex_rs1_i >= ex_rs2_i);
			default: taken = 1'b0;
		endcase
	end

	assign jalr_target = ex_rs1_i + ex_imm_i;

	always_comb begin
		case (ex_flow_i)
			FLOW_BRANCH: next_pc_o = taken ? ex_pc_i + ex_imm_i : ex_pc_i + 32'd4;
			FLOW_JAL:    next_pc_o = ex_pc_i + ex_imm_i;
			// target is halfword aligned by clearing bit 0
			FLOW_JALR:   next_pc_o = {jalr_target[31:1], 1'b0};
			default:     next_pc_o = ex_pc_i + 32'd4;
		endcase
	end

endmodule

/* verilog/rv_writeback.sv */
`timescale 1ns/1ps

module rv_writeback (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  ex_valid_i,
	input  rv_isa_pkg::xlen_t     ex_pc_i,
	input  logic                  ex_rd_wen_i,
	input  rv_isa_pkg::reg_addr_t ex_rd_addr_i,
	input  rv_isa_pkg::xlen_t     ex_result_i,
	input  rv_isa_pkg::xlen_t     ex_next_pc_i,
	input  logic                  commit_ready_i,
	output logic                  advance_o,
	output logic                  rd_wen_o,
	output rv_isa_pkg::reg_addr_t rd_addr_o,
	output rv_isa_pkg::xlen_t     rd_data_o,
	output logic                  commit_valid_o,
	output rv_isa_pkg::xlen_t     commit_pc_o,
	output logic                  commit_rd_wen_o,
	output rv_isa_pkg::reg_addr_t commit_rd_addr_o,
	output rv_isa_pkg::xlen_t     commit_rd_data_o,
	output rv_isa_pkg::xlen_t     commit_next_pc_o
);
	import rv_isa_pkg::*;

	logic  wb_rd_wen;
	xlen_t wb_result;

	// stage empty or draining this cycle
	assign advance_o = !commit_valid_o || commit_ready_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid_o <= 1'b0;
		end else if (advance_o) begin
			commit_valid_o <= ex_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (advance_o) begin
			commit_pc_o      <= ex_pc_i;
			wb_rd_wen        <= ex_rd_wen_i;
			rd_addr_o        <= ex_rd_addr_i;
			wb_result        <= ex_result_i;
			commit_next_pc_o <= ex_next_pc_i;
		end
	end

	// regfile only updates on the commit handshake
	assign rd_wen_o  = commit_valid_o && wb_rd_wen && commit_ready_i;
	assign rd_data_o = wb_result;

	// also the pending write flag seen by decode
	assign commit_rd_wen_o  = commit_valid_o && wb_rd_wen;
	assign commit_rd_addr_o = rd_addr_o;
	assign commit_rd_data_o = wb_rd_wen ? wb_result : '0;

endmodule

/* verilog/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  in_valid_i,
	input  rv_isa_pkg::xlen_t     in_pc_i,
	input  rv_isa_pkg::inst_t     in_inst_i,
	output logic                  in_ready_o,
	output logic                  commit_valid_o,
	output rv_isa_pkg::xlen_t     commit_pc_o,
	output logic                  commit_rd_wen_o,
	output rv_isa_pkg::reg_addr_t commit_rd_addr_o,
	output rv_isa_pkg::xlen_t     commit_rd_data_o,
	output rv_isa_pkg::xlen_t     commit_next_pc_o,
	input  logic                  commit_ready_i
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	xlen_t     rs1_data;
	xlen_t     rs2_data;
	logic      advance;

	logic      ex_valid;
	xlen_t     ex_pc;
	xlen_t     ex_rs1;
	xlen_t     ex_rs2;
	xlen_t     ex_imm;
	alu_op_e   ex_alu_op;
	src_a_e    ex_src_a;
	src_b_e    ex_src_b;
	flow_e     ex_flow;
	cmp_e      ex_cmp;
	logic      ex_rd_wen;
	reg_addr_t ex_rd_addr;
	xlen_t     ex_result;
	xlen_t     ex_next_pc;

	logic      rf_wen;
	reg_addr_t wb_rd_addr;
	xlen_t     wb_rd_data;

	assign in_ready_o = advance;

	rv_decode u_decode (
		.clock        (clock),
		.reset        (reset),
		.in_valid_i   (in_valid_i),
		.in_pc_i      (in_pc_i),
		.in_inst_i    (in_inst_i),
		.advance_i    (advance),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.ex_result_i  (ex_result),
		.wb_rd_wen_i  (commit_rd_wen_o),
		.wb_rd_addr_i (wb_rd_addr),
		.wb_rd_data_i (wb_rd_data),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.ex_valid_o   (ex_valid),
		.ex_pc_o      (ex_pc),
		.ex_rs1_o     (ex_rs1),
		.ex_rs2_o     (ex_rs2),
		.ex_imm_o     (ex_imm),
		.ex_alu_op_o  (ex_alu_op),
		.ex_src_a_o   (ex_src_a),
		.ex_src_b_o   (ex_src_b),
		.ex_flow_o    (ex_flow),
		.ex_cmp_o     (ex_cmp),
		.ex_rd_wen_o  (ex_rd_wen),
		.ex_rd_addr_o (ex_rd_addr)
	);

	rv_regfile u_regfile (
		.clock      (clock),
		.reset      (reset),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.wr_en_i    (rf_wen),
		.wr_addr_i  (wb_rd_addr),
		.wr_data_i  (wb_rd_data),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	rv_alu u_alu (
		.ex_pc_i     (ex_pc),
		.ex_rs1_i    (ex_rs1),
		.ex_rs2_i    (ex_rs2),
		.ex_imm_i    (ex_imm),
		.ex_alu_op_i (ex_alu_op),
		.ex_src_a_i  (ex_src_a),
		.ex_src_b_i  (ex_src_b),
		.result_o    (ex_result)
	);

	rv_branch_unit u_branch (
		.ex_pc_i   (ex_pc),
		.ex_rs1_i  (ex_rs1),
		.ex_imm_i  (ex_imm),
		.ex_rs2_i  (ex_rs2),
		.ex_flow_i (ex_flow),
		.ex_cmp_i  (ex_cmp),
		.next_pc_o (ex_next_pc)
	);

	rv_writeback u_writeback (
		.clock            (clock),
		.reset            (reset),
		.ex_valid_i       (ex_valid),
		.ex_pc_i          (ex_pc),
		.ex_rd_wen_i      (ex_rd_wen),
		.ex_rd_addr_i     (ex_rd_addr),
		.ex_result_i      (ex_result),
		.ex_next_pc_i     (ex_next_pc),
		.commit_ready_i   (commit_ready_i),
		.advance_o        (advance),
		.rd_wen_o         (rf_wen),
		.rd_addr_o        (wb_rd_addr),
		.rd_data_o        (wb_rd_data),
		.commit_valid_o   (commit_valid_o),
		.commit_pc_o      (commit_pc_o),
		.commit_rd_wen_o  (commit_rd_wen_o),
		.commit_rd_addr_o (commit_rd_addr_o),
		.commit_rd_data_o (commit_rd_data_o),
		.commit_next_pc_o (commit_next_pc_o)
	);

endmodule

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
	import rv_isa_pkg::*;

	localparam int          MAX_ENTRIES = 64;
	localparam logic [15:0] LFSR_SEED   = 16'd47741;

	logic      clock;
	logic      reset;
	logic      in_valid;
	xlen_t     in_pc;
	inst_t     in_inst;
	logic      in_ready;
	logic      commit_valid;
	xlen_t     commit_pc;
	logic      commit_rd_wen;
	reg_addr_t commit_rd_addr;
	xlen_t     commit_rd_data;
	xlen_t     commit_next_pc;
	logic      commit_ready;

	// each entry is five words of pc, inst, wen and rd, rd data and next pc
	logic [31:0] trace_mem [0:5*MAX_ENTRIES-1];
	int          n_entries;
	logic [15:0] lfsr_state;

	rv_core_top UUT (
		.clock            (clock),
		.reset            (reset),
		.in_valid_i       (in_valid),
		.in_pc_i          (in_pc),
		.in_inst_i        (in_inst),
		.in_ready_o       (in_ready),
		.commit_valid_o   (commit_valid),
		.commit_pc_o      (commit_pc),
		.commit_rd_wen_o  (commit_rd_wen),
		.commit_rd_addr_o (commit_rd_addr),
		.commit_rd_data_o (commit_rd_data),
		.commit_next_pc_o (commit_next_pc),
		.commit_ready_i   (commit_ready)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	task automatic random_bit(output logic b);
		b = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAILED %s expected %08h actual %08h", name, exp, act);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic require_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic check_commit(input int idx);
		logic [31:0] rd_info;
		string       tag;
		rd_info = trace_mem[5*idx+2];
		tag = $sformatf("trace[%0d]", idx);
		compare_value({tag, " pc"}, trace_mem[5*idx], commit_pc);
		compare_value({tag, " rd_wen"}, {31'b0, rd_info[8]}, {31'b0, commit_rd_wen});
		// rd address and data only mean something on a write
		if (rd_info[8]) begin
			compare_value({tag, " rd_addr"}, {27'b0, rd_info[4:0]}, {27'b0, commit_rd_addr});
			compare_value({tag, " rd_data"}, trace_mem[5*idx+3], commit_rd_data);
		end
		compare_value({tag, " next_pc"}, trace_mem[5*idx+4], commit_next_pc);
	endtask

	initial begin
		int        cyc;
		int        limit;
		int        next_in;
		int        committed;
		int        first_accept;
		logic      presenting;
		logic      in_fire;
		logic      seen_valid;
		logic      random_ready;
		logic      held;
		logic      b;
		logic      ex_busy;
		logic      wb_busy;
		logic      exp_ready;
		xlen_t     held_pc;
		logic      held_wen;
		reg_addr_t held_addr;
		xlen_t     held_data;
		xlen_t     held_next;

		reset        = 1'b1;
		in_valid     = 1'b0;
		in_pc        = '0;
		in_inst      = '0;
		commit_ready = 1'b1;
		lfsr_state   = LFSR_SEED;
		// words past the end of the trace keep this pattern
		for (int i = 0; i < 5*MAX_ENTRIES; i++) begin
			trace_mem[i] = ~32'(i);
		end
		$readmemh("tb/rv_core_trace.txt", trace_mem);
		n_entries = 0;
		while (n_entries < MAX_ENTRIES && trace_mem[5*n_entries] != ~32'(5*n_entries)) begin
			n_entries++;
		end
		require_true(n_entries > 0, "trace file holds no instructions");
		limit = 10 * n_entries + 50;

		cyc          = 0;
		next_in      = 0;
		committed    = 0;
		first_accept = -1;
		seen_valid   = 1'b0;
		random_ready = 1'b0;
		held         = 1'b0;
		ex_busy      = 1'b0;
		wb_busy      = 1'b0;
		exp_ready    = 1'b1;
		held_pc      = '0;
		held_wen     = 1'b0;
		held_addr    = '0;
		held_data    = '0;
		held_next    = '0;

		repeat (5) @(posedge clock);
		#5;
		reset = 1'b0;
		// first instruction goes in without a gap for the latency check
		presenting = 1'b1;
		in_valid   = 1'b1;
		in_pc      = trace_mem[0];
		in_inst    = trace_mem[1];

		while (committed < n_entries) begin
			@(negedge clock);
			cyc++;
			if (cyc > limit) begin
				$display("timeout after %0d cycles, %0d of %0d instructions committed",
					cyc, committed, n_entries);
				$display("=== FAIL ===");
				$fatal(1);
			end
			if (cyc == 1) begin
				compare_value("reset commit_valid", 32'd0, {31'b0, commit_valid});
				compare_value("reset in_ready", 32'd1, {31'b0, in_ready});
			end
			if (held) begin
				require_true(commit_valid, "commit_valid_o dropped while commit_ready_i was low");
				compare_value("hold commit_pc", held_pc, commit_pc);
				compare_value("hold commit_rd_wen", {31'b0, held_wen}, {31'b0, commit_rd_wen});
				compare_value("hold commit_rd_addr", {27'b0, held_addr}, {27'b0, commit_rd_addr});
				compare_value("hold commit_rd_data", held_data, commit_rd_data);
				compare_value("hold commit_next_pc", held_next, commit_next_pc);
			end
			if (commit_valid && !seen_valid) begin
				seen_valid = 1'b1;
				compare_value("latency", first_accept + 2, cyc);
			end
			exp_ready = !wb_busy || commit_ready;
			compare_value("commit_valid", {31'b0, wb_busy}, {31'b0, commit_valid});
			compare_value("in_ready", {31'b0, exp_ready}, {31'b0, in_ready});
			if (commit_valid && commit_ready) begin
				check_commit(committed);
				committed++;
				random_ready = 1'b1;
			end
			held      = commit_valid && !commit_ready;
			held_pc   = commit_pc;
			held_wen  = commit_rd_wen;
			held_addr = commit_rd_addr;
			held_data = commit_rd_data;
			held_next = commit_next_pc;
			in_fire   = in_valid && in_ready;
			if (in_fire && next_in == 0)
				first_accept = cyc;
			// stage occupancy moves on with the pipeline advance
			if (exp_ready) begin
				wb_busy = ex_busy;
				ex_busy = in_valid;
			end

			@(posedge clock);
			#5;
			if (in_fire) begin
				next_in++;
				presenting = 1'b0;
			end
			if (!presenting && next_in < n_entries) begin
				random_bit(b);
				presenting = b;
			end
			in_valid = presenting;
			if (presenting) begin
				in_pc   = trace_mem[5*next_in];
				in_inst = trace_mem[5*next_in+1];
			end
			if (random_ready) begin
				random_bit(b);
				commit_ready = !b;
			end
		end

		repeat (3) begin
			@(negedge clock);
			require_true(!commit_valid, "commit_valid_o rose after the last instruction committed");
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* tb/rv_core_trace.txt */
// pc inst wen_rd rd_data next_pc, all hex
// wen_rd is 1 followed by rd for a write, 000 for no write
00000100 FFFFF0B7 101 FFFFF000 00000104
00000104 FFB08113 102 FFFFEFFB 00000108
00000108 40415193 103 FFFFFEFF 0000010C
0000010C 00112233 104 00000001 00000110
00000110 0041B2B3 105 00000000 00000114
00000114 40120333 106 00001001 00000118
00000118 004313B3 107 00002002 0000011C
0000011C FFF3C413 108 FFFFDFFD 00000120
00000120 004454B3 109 7FFFEFFE 00000124
00000124 0084F533 10A 7FFFCFFC 00000128
00000128 12356013 000 00000000 0000012C
0000012C 007005B3 10B 00002002 00000130
00000130 00001617 10C 00001130 00000134
00000134 00002303 000 00000000 00000138
00000138 00030693 10D 00001001 0000013C
0000013C 00668463 000 00000000 00000144
00000144 00B68463 000 00000000 00000148
00000148 00521463 000 00000000 00000150
00000150 00B39463 000 00000000 00000154
00000154 0040C463 000 00000000 0000015C
0000015C 00124463 000 00000000 00000160
00000160 00125463 000 00000000 00000168
00000168 0040D463 000 00000000 0000016C
0000016C 00126463 000 00000000 00000174
00000174 0040E463 000 00000000 00000178
00000178 0040F463 000 00000000 00000180
00000180 0042F463 000 00000000 00000184
00000184 0200076F 10E 00000188 000001A4
000001A4 041707E7 10F 000001A8 000001C8
000001C8 00E78833 110 00000330 000001CC
000001CC FF9FF06F 000 00000000 000001C4
000001C4 00C808B3 111 00001460 000001C8

/* build.f */
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_branch_unit.sv
verilog/rv_writeback.sv
verilog/rv_core_top.sv
tb/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the rv core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module rv_core_tb -Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
